// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: gp0_i, gp1_i, opcode, word address, write data, byte enables,
// expected resp_data_o, expected irq_o, expected gp0_o

localparam int VEC_COUNT = 31;

task automatic load_vectors();
	// Device table
	add_vec(16'h0000, 5'h00, OP_RD, 30'd0, 32'h0, 4'hF, devtbl_expect(4'd0), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd1, 32'h0, 4'hF, devtbl_expect(4'd1), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd2, 32'h0, 4'hF, devtbl_expect(4'd2), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd3, 32'h0, 4'hF, devtbl_expect(4'd3), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd4, 32'h0, 4'hF, devtbl_expect(4'd4), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd5, 32'h0, 4'hF, devtbl_expect(4'd5), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd6, 32'h0, 4'hF, devtbl_expect(4'd6), 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd7, 32'h0, 4'hF, 32'h0, 1'b0, 16'h0000);
	add_vec(16'h0000, 5'h00, OP_RD, 30'd14, 32'h0, 4'hF, 32'h0, 1'b0, 16'h0000);
	// gp0 change with nothing enabled, pending only
	add_vec(16'h00A5, 5'h00, OP_RD, 30'd24, 32'h0, 4'hF, 32'h1, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h00, OP_RD, 30'd16, 32'h0, 4'hF, 32'h00A5, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h00, OP_WR, 30'd24, 32'h1, 4'hF, 32'h0, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h00, OP_WR, 30'd25, 32'h3, 4'hF, 32'h0, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h00, OP_RD, 30'd25, 32'h0, 4'hF, 32'h3, 1'b0, 16'h0000);
	// Button change with both sources enabled
	add_vec(16'h00A5, 5'h11, OP_RD, 30'd20, 32'h0, 4'hF, 32'h11, 1'b1, 16'h0000);
	add_vec(16'h00A5, 5'h11, OP_RD, 30'd24, 32'h0, 4'hF, 32'h2, 1'b1, 16'h0000);
	add_vec(16'h00A5, 5'h11, OP_WR, 30'd24, 32'h2, 4'hF, 32'h0, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h11, OP_RD, 30'd24, 32'h0, 4'hF, 32'h0, 1'b0, 16'h0000);
	// Only gp0 enabled, so a button change stays quiet
	add_vec(16'h00A5, 5'h11, OP_WR, 30'd25, 32'h1, 4'hF, 32'h0, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h03, OP_RD, 30'd24, 32'h0, 4'hF, 32'h2, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h03, OP_RD, 30'd20, 32'h0, 4'hF, 32'h03, 1'b0, 16'h0000);
	add_vec(16'h00A5, 5'h03, OP_WR, 30'd24, 32'h3, 4'hF, 32'h0, 1'b0, 16'h0000);
	// Output register with byte enables
	add_vec(16'h00A5, 5'h03, OP_WR, 30'd17, 32'h1234, 4'hF, 32'h0, 1'b0, 16'h1234);
	add_vec(16'h00A5, 5'h03, OP_RW, 30'd17, 32'hABCD, 4'hF, 32'h1234, 1'b0, 16'hABCD);
	add_vec(16'h00A5, 5'h03, OP_WR, 30'd17, 32'h5600, 4'h2, 32'h0, 1'b0, 16'h56CD);
	add_vec(16'h00A5, 5'h03, OP_WR, 30'd17, 32'hFFFF_FF77, 4'h1, 32'h0, 1'b0, 16'h5677);
	add_vec(16'h00A5, 5'h03, OP_RD, 30'd17, 32'h0, 4'hF, 32'h5677, 1'b0, 16'h5677);
	add_vec(16'h00A5, 5'h03, OP_RD, 30'd21, 32'h0, 4'hF, 32'h0, 1'b0, 16'h5677);
	// Unmapped addresses
	add_vec(16'h00A5, 5'h03, OP_RD, 30'd28, 32'h0, 4'hF, 32'h0, 1'b0, 16'h5677);
	add_vec(16'h00A5, 5'h03, OP_RD, 30'h3FFF_FFFF, 32'h0, 4'hF, 32'h0, 1'b0, 16'h5677);
	add_vec(16'h00A5, 5'h03, OP_RW, 30'd100, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0, 16'h5677);
endtask

`endif

// File: dv/tb_soc_periph.sv
`timescale 1ns/100ps

module tb_soc_periph
	import soc_pkg::*;
();

	localparam int RST_BITS   = 4;
	localparam int RAND_READS = 32;

	`include "tb_vectors.svh"

	localparam int WD_CYCLES = (VEC_COUNT + RAND_READS) * 20 + (2 ** RST_BITS) * 4;

	logic        clk_2x_w;
	logic        rst_p;
	logic        req_stb_i;
	pi_op_e      req_op_i;
	addr_t       req_addr_i;
	word_t       req_data_i;
	sel_t        req_sel_i;
	logic [15:0] gp0_i;
	logic [4:0]  gp1_i;
	logic        resp_stb_o;
	word_t       resp_data_o;
	logic [15:0] gp0_o;
	logic        irq_o;
	logic        rst_busy_o;

	int          vec_fill = 0;
	logic [15:0] vec_gp0 [VEC_COUNT];
	logic [4:0]  vec_gp1 [VEC_COUNT];
	pi_op_e      vec_op [VEC_COUNT];
	addr_t       vec_addr [VEC_COUNT];
	word_t       vec_data [VEC_COUNT];
	sel_t        vec_sel [VEC_COUNT];
	word_t       vec_exp [VEC_COUNT];
	logic        vec_irq [VEC_COUNT];
	logic [15:0] vec_gpo [VEC_COUNT];
	logic [3:0]  rd_ofs [RAND_READS];

	soc_periph_top #(
		.RST_CNTR_BITSZ (RST_BITS),
		.GP0_IOCOUNT    (16),
		.GP1_IOCOUNT    (5)
	) DUT (
		.clk_2x_w    (clk_2x_w),
		.rst_p       (rst_p),
		.req_stb_i   (req_stb_i),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.req_data_i  (req_data_i),
		.req_sel_i   (req_sel_i),
		.gp0_i       (gp0_i),
		.gp1_i       (gp1_i),
		.resp_stb_o  (resp_stb_o),
		.resp_data_o (resp_data_o),
		.gp0_o       (gp0_o),
		.irq_o       (irq_o),
		.rst_busy_o  (rst_busy_o)
	);

	always #5 clk_2x_w = ~clk_2x_w;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// Id in 7..0, interrupt use in 8, map size in 31..16
	function automatic word_t entry_word(input logic [7:0] id, input logic use_irq,
			input logic [15:0] mapsz);
		return {mapsz, 7'd0, use_irq, id};
	endfunction

	function automatic word_t devtbl_expect(input logic [3:0] ofs);
		case (ofs)
			4'd0:    return SOC_ID;
			4'd1:    return 32'd5;
			4'd2:    return entry_word(ID_DEVTBL, 1'b0, 16'd16);
			4'd3:    return entry_word(ID_GPIO, 1'b1, 16'd4);
			4'd4:    return entry_word(ID_GPIO, 1'b1, 16'd4);
			4'd5:    return entry_word(ID_INTCTRL, 1'b1, 16'd4);
			4'd6:    return entry_word(ID_INVALID, 1'b0, 16'd0);
			default: return 32'd0;
		endcase
	endfunction

	task automatic add_vec(input logic [15:0] g0, input logic [4:0] g1, input pi_op_e op,
			input addr_t addr, input word_t data, input sel_t sel, input word_t exp,
			input logic irq, input logic [15:0] gpo);
		vec_gp0[vec_fill]  = g0;
		vec_gp1[vec_fill]  = g1;
		vec_op[vec_fill]   = op;
		vec_addr[vec_fill] = addr;
		vec_data[vec_fill] = data;
		vec_sel[vec_fill]  = sel;
		vec_exp[vec_fill]  = exp;
		vec_irq[vec_fill]  = irq;
		vec_gpo[vec_fill]  = gpo;
		vec_fill++;
	endtask

	task automatic drive_idle();
		req_stb_i  = 1'b0;
		req_op_i   = OP_NOP;
		req_addr_i = '0;
		req_data_i = '0;
		req_sel_i  = '0;
	endtask

	// One request for one cycle, driven between rising edges
	task automatic issue_req(input pi_op_e op, input addr_t addr, input word_t data,
			input sel_t sel);
		req_stb_i  = 1'b1;
		req_op_i   = op;
		req_addr_i = addr;
		req_data_i = data;
		req_sel_i  = sel;
		@(negedge clk_2x_w);
		drive_idle();
	endtask

	task automatic wait_resp(input string what);
		int cnt;
		cnt = 0;
		while (!resp_stb_o && cnt < 8) begin
			@(negedge clk_2x_w);
			cnt++;
		end
		if (!resp_stb_o) begin
			abort_run($sformatf("No response to %s within 8 cycles", what));
		end
	endtask

	task automatic wait_rst_release();
		int cnt;
		cnt = 0;
		while (rst_busy_o && cnt < (2 ** RST_BITS) + 8) begin
			@(negedge clk_2x_w);
			cnt++;
		end
		if (rst_busy_o) begin
			abort_run("Internal reset did not release in time");
		end
	endtask

	task automatic run_vectors();
		for (int i = 0; i < VEC_COUNT; i++) begin
			gp0_i = vec_gp0[i];
			gp1_i = vec_gp1[i];
			repeat (4) @(negedge clk_2x_w);
			issue_req(vec_op[i], vec_addr[i], vec_data[i], vec_sel[i]);
			wait_resp($sformatf("table row %0d", i));
			check_word("resp_data_o", resp_data_o, vec_exp[i]);
			check_flag("irq_o", irq_o, vec_irq[i]);
			check_word("gp0_o", word_t'(gp0_o), word_t'(vec_gpo[i]));
			@(negedge clk_2x_w);
		end
	endtask

	// Back-to-back reads, each response due on the third falling edge after its drive
	task automatic run_pipelined_reads();
		for (int i = 0; i < RAND_READS; i++) begin
			rd_ofs[i] = 4'($urandom % 16);
		end
		fork
			begin : issue_blk
				for (int k = 0; k < RAND_READS; k++) begin
					req_stb_i  = 1'b1;
					req_op_i   = OP_RD;
					req_addr_i = addr_t'(rd_ofs[k]);
					req_sel_i  = 4'hF;
					@(negedge clk_2x_w);
				end
				drive_idle();
			end
			begin : collect_blk
				repeat (3) @(negedge clk_2x_w);
				for (int k = 0; k < RAND_READS; k++) begin
					check_flag("resp_stb_o", resp_stb_o, 1'b1);
					check_word("resp_data_o", resp_data_o, devtbl_expect(rd_ofs[k]));
					@(negedge clk_2x_w);
				end
				check_flag("resp_stb_o", resp_stb_o, 1'b0);
			end
		join
	endtask

	task automatic run_soft_reset();
		// Enabled gp0 change raises the interrupt
		gp0_i = 16'h005A;
		repeat (4) @(negedge clk_2x_w);
		check_flag("irq_o", irq_o, 1'b1);
		// Warm reset clears interrupt state and the output register
		issue_req(OP_WR, 30'd15, 32'h2, 4'hF);
		wait_resp("warm reset write");
		check_word("resp_data_o", resp_data_o, 32'h0);
		@(negedge clk_2x_w);
		check_flag("rst_busy_o", rst_busy_o, 1'b1);
		wait_rst_release();
		check_word("gp0_o", word_t'(gp0_o), 32'h0);
		check_flag("irq_o", irq_o, 1'b0);
		issue_req(OP_RD, 30'd17, 32'h0, 4'hF);
		wait_resp("read after warm reset");
		check_word("resp_data_o", resp_data_o, 32'h0);
		@(negedge clk_2x_w);
		issue_req(OP_WR, 30'd17, 32'h00C3, 4'hF);
		wait_resp("output write");
		check_word("resp_data_o", resp_data_o, 32'h0);
		check_word("gp0_o", word_t'(gp0_o), 32'h00C3);
		@(negedge clk_2x_w);
		// Power-off holds the internal reset and swallows requests
		issue_req(OP_WR, 30'd15, 32'h1, 4'hF);
		wait_resp("power-off write");
		check_word("resp_data_o", resp_data_o, 32'h0);
		@(negedge clk_2x_w);
		issue_req(OP_RD, 30'd0, 32'h0, 4'hF);
		repeat ((2 ** RST_BITS) * 2) begin
			check_flag("rst_busy_o", rst_busy_o, 1'b1);
			check_flag("resp_stb_o", resp_stb_o, 1'b0);
			@(negedge clk_2x_w);
		end
		// Board reset brings the system back
		rst_p = 1'b1;
		repeat (3) @(negedge clk_2x_w);
		rst_p = 1'b0;
		wait_rst_release();
		issue_req(OP_RD, 30'd0, 32'h0, 4'hF);
		wait_resp("read after board reset");
		check_word("resp_data_o", resp_data_o, SOC_ID);
		check_word("gp0_o", word_t'(gp0_o), 32'h0);
		@(negedge clk_2x_w);
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk_2x_w);
		abort_run($sformatf("Watchdog expired after %0d cycles", WD_CYCLES));
	end

	initial begin
		void'($urandom(28180));
		clk_2x_w = 1'b0;
		rst_p    = 1'b1;
		gp0_i    = '0;
		gp1_i    = '0;
		drive_idle();
		load_vectors();
		repeat (3) @(posedge clk_2x_w);
		@(negedge clk_2x_w);
		rst_p = 1'b0;
		wait_rst_release();
		run_vectors();
		run_pipelined_reads();
		run_soft_reset();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: hdl/devtbl_regs.sv
`timescale 1ns/100ps

module devtbl_regs
	import soc_pkg::*;
(
	input  logic       clk_2x_w,
	input  logic       rst_w,
	input  logic       dec_stb_i,
	input  logic       sel_i,
	input  logic [3:0] ofs_i,
	input  pi_op_e     op_i,
	input  word_t      data_i,
	input  sel_t       be_i,
	output word_t      rdata_o,
	output logic       warm_stb_o,
	output logic       pwroff_stb_o
);

	logic  acc_w;
	logic  rst_wr_w;
	word_t wr_val;
	word_t read_c;

	assign acc_w    = dec_stb_i && sel_i;
	assign rst_wr_w = acc_w && op_writes(op_i) && (ofs_i == DT_RST_OFS);
	assign wr_val   = be_merge('0, data_i, be_i);

	// Table is read-only, built from the map constants
	always_comb begin
		read_c = '0;
		if (ofs_i == DT_SOCID_OFS) begin
			read_c = SOC_ID;
		end else if (ofs_i == DT_COUNT_OFS) begin
			read_c = word_t'(DEVCOUNT);
		end else if ((ofs_i >= DT_ENTRY_OFS) && (ofs_i < (DT_ENTRY_OFS + DEVCOUNT))) begin
			read_c = dev_entry(dev_idx_t'(ofs_i - DT_ENTRY_OFS));
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (acc_w) begin
			rdata_o <= read_c;
		end
	end

	// Reset command in bits 1..0
	// 2 is warm reset, 1 is power-off, 3 would be cold reset and is ignored
	always_ff @(posedge clk_2x_w) begin
		if (rst_w) begin
			warm_stb_o   <= 1'b0;
			pwroff_stb_o <= 1'b0;
		end else begin
			warm_stb_o   <= rst_wr_w && (wr_val[1:0] == 2'd2);
			pwroff_stb_o <= rst_wr_w && (wr_val[1:0] == 2'd1);
		end
	end

endmodule

// File: hdl/gpio_port.sv
`timescale 1ns/100ps

module gpio_port
	import soc_pkg::*;
#(
	parameter int IOCOUNT = 16
) (
	input  logic               clk_2x_w,
	input  logic               rst_w,
	input  logic               dec_stb_i,
	input  logic               sel_i,
	input  logic [3:0]         ofs_i,
	input  pi_op_e             op_i,
	input  word_t              data_i,
	input  sel_t               be_i,
	input  logic [IOCOUNT-1:0] pins_i,
	output word_t              rdata_o,
	output logic [IOCOUNT-1:0] pins_o,
	output logic               chg_stb_o
);

	logic [IOCOUNT-1:0] sync1_r;
	logic [IOCOUNT-1:0] sync2_r;
	logic [IOCOUNT-1:0] prev_r;
	logic [IOCOUNT-1:0] out_r;
	logic               acc_w;
	logic               out_wr_w;
	word_t              wr_val;
	word_t              read_c;

	assign acc_w    = dec_stb_i && sel_i;
	assign out_wr_w = acc_w && op_writes(op_i) && (ofs_i == GP_OUT_OFS);
	assign wr_val   = be_merge(word_t'(out_r), data_i, be_i);
	assign pins_o   = out_r;

	// Two-flop synchronizer, then last cycle's value for edge detection
	// These keep tracking the pins during reset so no change is seen on release
	always_ff @(posedge clk_2x_w) begin
		sync1_r <= pins_i;
		sync2_r <= sync1_r;
		prev_r  <= sync2_r;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_w) begin
			out_r     <= '0;
			chg_stb_o <= 1'b0;
		end else begin
			chg_stb_o <= (sync2_r != prev_r);
			if (out_wr_w) begin
				out_r <= wr_val[IOCOUNT-1:0];
			end
		end
	end

	always_comb begin
		read_c = '0;
		if (ofs_i == GP_IN_OFS) begin
			read_c = word_t'(sync2_r);
		end else if (ofs_i == GP_OUT_OFS) begin
			read_c = word_t'(out_r);
		end
	end

	// Old value is captured on the same edge that a write lands
	always_ff @(posedge clk_2x_w) begin
		if (acc_w) begin
			rdata_o <= read_c;
		end
	end

endmodule

// File: hdl/intctrl.sv
`timescale 1ns/100ps

module intctrl
	import soc_pkg::*;
#(
	parameter int SRCCOUNT = 2
) (
	input  logic                clk_2x_w,
	input  logic                rst_w,
	input  logic                dec_stb_i,
	input  logic                sel_i,
	input  logic [3:0]          ofs_i,
	input  pi_op_e              op_i,
	input  word_t               data_i,
	input  sel_t                be_i,
	input  logic [SRCCOUNT-1:0] src_stb_i,
	output word_t               rdata_o,
	output logic                irq_o
);

	logic [SRCCOUNT-1:0] pend_r;
	logic [SRCCOUNT-1:0] en_r;
	logic [SRCCOUNT-1:0] clr_c;
	logic                acc_w;
	logic                wr_w;
	word_t               wr_val;
	word_t               read_c;

	assign acc_w  = dec_stb_i && sel_i;
	assign wr_w   = acc_w && op_writes(op_i);
	assign wr_val = be_merge('0, data_i, be_i);

	// Write-one-to-clear on the pending word
	assign clr_c = (wr_w && (ofs_i == IC_PEND_OFS)) ? wr_val[SRCCOUNT-1:0] : '0;

	always_ff @(posedge clk_2x_w) begin
		if (rst_w) begin
			pend_r <= '0;
			en_r   <= '0;
		end else begin
			// A new event beats a clear on the same edge
			pend_r <= (pend_r & ~clr_c) | src_stb_i;
			if (wr_w && (ofs_i == IC_EN_OFS)) begin
				en_r <= wr_val[SRCCOUNT-1:0];
			end
		end
	end

	assign irq_o = |(pend_r & en_r);

	always_comb begin
		read_c = '0;
		if (ofs_i == IC_PEND_OFS) begin
			read_c = word_t'(pend_r);
		end else if (ofs_i == IC_EN_OFS) begin
			read_c = word_t'(en_r);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (acc_w) begin
			rdata_o <= read_c;
		end
	end

	// Internal reset comes from reset_seq, request must be gone one edge later
	a_irq_in_reset: assert property (@(posedge clk_2x_w)
		rst_w |=> !irq_o)
		else $error("intctrl: irq_o high during reset");

endmodule

// File: hdl/pi_decode.sv
`timescale 1ns/100ps

module pi_decode
	import soc_pkg::*;
(
	input  logic                clk_2x_w,
	input  logic                rst_w,
	input  logic                req_stb_i,
	input  pi_op_e              req_op_i,
	input  addr_t               req_addr_i,
	input  word_t               req_data_i,
	input  sel_t                req_sel_i,
	output logic                dec_stb_o,
	output logic [DEVCOUNT-1:0] dec_sel_o,
	output dev_idx_t            dec_idx_o,
	output logic [3:0]          dec_ofs_o,
	output pi_op_e              dec_op_o,
	output word_t               dec_data_o,
	output sel_t                dec_be_o
);

	logic [DEVCOUNT-1:0] sel_c;
	dev_idx_t            idx_c;
	logic [3:0]          ofs_c;

	function automatic logic in_map(input addr_t a, input addr_t base, input addr_t sz);
		return (a >= base) && (a < (base + sz));
	endfunction

	// One match per device window
	// Nothing matched selects the invalid device
	always_comb begin
		sel_c              = '0;
		sel_c[DEV_DEVTBL]  = in_map(req_addr_i, DEVTBL_BASE, DEVTBL_MAPSZ);
		sel_c[DEV_GP0]     = in_map(req_addr_i, GP0_BASE, GP0_MAPSZ);
		sel_c[DEV_GP1]     = in_map(req_addr_i, GP1_BASE, GP1_MAPSZ);
		sel_c[DEV_INTCTRL] = in_map(req_addr_i, INTCTRL_BASE, INTCTRL_MAPSZ);
		sel_c[DEV_INVALID] = !(sel_c[DEV_DEVTBL] || sel_c[DEV_GP0] || sel_c[DEV_GP1]
			|| sel_c[DEV_INTCTRL]);
	end

	// Address match against the map, anything unmatched lands on the invalid device
	always_comb begin
		idx_c = DEV_INVALID;
		ofs_c = '0;
		if (in_map(req_addr_i, DEVTBL_BASE, DEVTBL_MAPSZ)) begin
			idx_c = DEV_DEVTBL;
			ofs_c = 4'(req_addr_i - DEVTBL_BASE);
		end else if (in_map(req_addr_i, GP0_BASE, GP0_MAPSZ)) begin
			idx_c = DEV_GP0;
			ofs_c = 4'(req_addr_i - GP0_BASE);
		end else if (in_map(req_addr_i, GP1_BASE, GP1_MAPSZ)) begin
			idx_c = DEV_GP1;
			ofs_c = 4'(req_addr_i - GP1_BASE);
		end else if (in_map(req_addr_i, INTCTRL_BASE, INTCTRL_MAPSZ)) begin
			idx_c = DEV_INTCTRL;
			ofs_c = 4'(req_addr_i - INTCTRL_BASE);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_w) begin
			dec_stb_o <= 1'b0;
			dec_sel_o <= '0;
		end else begin
			// NOP requests never reach a device
			dec_stb_o <= req_stb_i && (req_op_i != OP_NOP);
			dec_sel_o <= sel_c;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		dec_idx_o  <= idx_c;
		dec_ofs_o  <= ofs_c;
		dec_op_o   <= req_op_i;
		dec_data_o <= req_data_i;
		dec_be_o   <= req_sel_i;
	end

	a_sel_onehot: assert property (@(posedge clk_2x_w) disable iff (rst_w)
		dec_stb_o |-> $onehot(dec_sel_o))
		else $error("pi_decode: device select not one-hot");

endmodule

// File: hdl/pi_respmux.sv
`timescale 1ns/100ps

module pi_respmux
	import soc_pkg::*;
(
	input  logic     clk_2x_w,
	input  logic     rst_w,
	input  logic     dec_stb_i,
	input  dev_idx_t dec_idx_i,
	input  pi_op_e   dec_op_i,
	input  word_t    devtbl_rdata_i,
	input  word_t    gp0_rdata_i,
	input  word_t    gp1_rdata_i,
	input  word_t    intc_rdata_i,
	output logic     resp_stb_o,
	output word_t    resp_data_o
);

	// Request info aligned with the device read stage
	logic     stb_d;
	dev_idx_t idx_d;
	logic     wr_d;
	word_t    sel_data;

	always_ff @(posedge clk_2x_w) begin
		if (rst_w) begin
			stb_d      <= 1'b0;
			resp_stb_o <= 1'b0;
		end else begin
			stb_d      <= dec_stb_i;
			resp_stb_o <= stb_d;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		idx_d       <= dec_idx_i;
		wr_d        <= (dec_op_i == OP_WR);
		resp_data_o <= sel_data;
	end

	// Plain writes and the invalid device return zero
	always_comb begin
		sel_data = '0;
		if (!wr_d) begin
			case (idx_d)
				DEV_DEVTBL:  sel_data = devtbl_rdata_i;
				DEV_GP0:     sel_data = gp0_rdata_i;
				DEV_GP1:     sel_data = gp1_rdata_i;
				DEV_INTCTRL: sel_data = intc_rdata_i;
				default:     sel_data = '0;
			endcase
		end
	end

	a_resp_follows_req: assert property (@(posedge clk_2x_w) disable iff (rst_w)
		resp_stb_o |-> $past(stb_d))
		else $error("pi_respmux: response without a request");

endmodule

// File: hdl/reset_seq.sv
`timescale 1ns/100ps

module reset_seq #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic warm_stb_i,
	input  logic pwroff_stb_i,
	output logic rst_w
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_r;

	// Reload on external or warm reset, then count down to zero
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_stb_i) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off holds the system until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_r <= 1'b0;
		end else if (pwroff_stb_i) begin
			pwroff_r <= 1'b1;
		end
	end

	assign rst_w = rst_p || pwroff_r || (rst_cntr != '0);

endmodule

// File: hdl/soc_periph_top.sv
`timescale 1ns/100ps

module soc_periph_top
	import soc_pkg::*;
#(
	parameter int RST_CNTR_BITSZ = 4,
	parameter int GP0_IOCOUNT    = 16,
	parameter int GP1_IOCOUNT    = 5
) (
	input  logic                   clk_2x_w,
	input  logic                   rst_p,
	input  logic                   req_stb_i,
	input  pi_op_e                 req_op_i,
	input  addr_t                  req_addr_i,
	input  word_t                  req_data_i,
	input  sel_t                   req_sel_i,
	input  logic [GP0_IOCOUNT-1:0] gp0_i,
	input  logic [GP1_IOCOUNT-1:0] gp1_i,
	output logic                   resp_stb_o,
	output word_t                  resp_data_o,
	output logic [GP0_IOCOUNT-1:0] gp0_o,
	output logic                   irq_o,
	output logic                   rst_busy_o
);

	logic                    rst_w;
	logic                    warm_stb_w;
	logic                    pwroff_stb_w;
	logic                    dec_stb_w;
	logic [DEVCOUNT-1:0]     dec_sel_w;
	dev_idx_t                dec_idx_w;
	logic [3:0]              dec_ofs_w;
	pi_op_e                  dec_op_w;
	word_t                   dec_data_w;
	sel_t                    dec_be_w;
	word_t                   devtbl_rdata_w;
	word_t                   gp0_rdata_w;
	word_t                   gp1_rdata_w;
	word_t                   intc_rdata_w;
	logic [INTSRC_COUNT-1:0] chg_stb_w;

	assign rst_busy_o = rst_w;

	reset_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_reset_seq (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.warm_stb_i   (warm_stb_w),
		.pwroff_stb_i (pwroff_stb_w),
		.rst_w        (rst_w)
	);

	pi_decode u_pi_decode (
		.clk_2x_w   (clk_2x_w),
		.rst_w      (rst_w),
		.req_stb_i  (req_stb_i),
		.req_op_i   (req_op_i),
		.req_addr_i (req_addr_i),
		.req_data_i (req_data_i),
		.req_sel_i  (req_sel_i),
		.dec_stb_o  (dec_stb_w),
		.dec_sel_o  (dec_sel_w),
		.dec_idx_o  (dec_idx_w),
		.dec_ofs_o  (dec_ofs_w),
		.dec_op_o   (dec_op_w),
		.dec_data_o (dec_data_w),
		.dec_be_o   (dec_be_w)
	);

	devtbl_regs u_devtbl (
		.clk_2x_w     (clk_2x_w),
		.rst_w        (rst_w),
		.dec_stb_i    (dec_stb_w),
		.sel_i        (dec_sel_w[DEV_DEVTBL]),
		.ofs_i        (dec_ofs_w),
		.op_i         (dec_op_w),
		.data_i       (dec_data_w),
		.be_i         (dec_be_w),
		.rdata_o      (devtbl_rdata_w),
		.warm_stb_o   (warm_stb_w),
		.pwroff_stb_o (pwroff_stb_w)
	);

	gpio_port #(
		.IOCOUNT (GP0_IOCOUNT)
	) u_gp0 (
		.clk_2x_w  (clk_2x_w),
		.rst_w     (rst_w),
		.dec_stb_i (dec_stb_w),
		.sel_i     (dec_sel_w[DEV_GP0]),
		.ofs_i     (dec_ofs_w),
		.op_i      (dec_op_w),
		.data_i    (dec_data_w),
		.be_i      (dec_be_w),
		.pins_i    (gp0_i),
		.rdata_o   (gp0_rdata_w),
		.pins_o    (gp0_o),
		.chg_stb_o (chg_stb_w[INTSRC_GP0])
	);

	// Buttons are input only
	gpio_port #(
		.IOCOUNT (GP1_IOCOUNT)
	) u_gp1 (
		.clk_2x_w  (clk_2x_w),
		.rst_w     (rst_w),
		.dec_stb_i (dec_stb_w),
		.sel_i     (dec_sel_w[DEV_GP1]),
		.ofs_i     (dec_ofs_w),
		.op_i      (dec_op_w),
		.data_i    (dec_data_w),
		.be_i      (dec_be_w),
		.pins_i    (gp1_i),
		.rdata_o   (gp1_rdata_w),
		.pins_o    (),
		.chg_stb_o (chg_stb_w[INTSRC_GP1])
	);

	intctrl #(
		.SRCCOUNT (INTSRC_COUNT)
	) u_intctrl (
		.clk_2x_w  (clk_2x_w),
		.rst_w     (rst_w),
		.dec_stb_i (dec_stb_w),
		.sel_i     (dec_sel_w[DEV_INTCTRL]),
		.ofs_i     (dec_ofs_w),
		.op_i      (dec_op_w),
		.data_i    (dec_data_w),
		.be_i      (dec_be_w),
		.src_stb_i (chg_stb_w),
		.rdata_o   (intc_rdata_w),
		.irq_o     (irq_o)
	);

	pi_respmux u_pi_respmux (
		.clk_2x_w       (clk_2x_w),
		.rst_w          (rst_w),
		.dec_stb_i      (dec_stb_w),
		.dec_idx_i      (dec_idx_w),
		.dec_op_i       (dec_op_w),
		.devtbl_rdata_i (devtbl_rdata_w),
		.gp0_rdata_i    (gp0_rdata_w),
		.gp1_rdata_i    (gp1_rdata_w),
		.intc_rdata_i   (intc_rdata_w),
		.resp_stb_o     (resp_stb_o),
		.resp_data_o    (resp_data_o)
	);

endmodule

// File: hdl/soc_pkg.sv
package soc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [29:0] addr_t;
	typedef logic [3:0]  sel_t;
	typedef logic [2:0]  dev_idx_t;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_WR  = 2'd1,
		OP_RD  = 2'd2,
		// Writes the new value and returns the old one
		OP_RW  = 2'd3
	} pi_op_e;

	localparam dev_idx_t DEV_DEVTBL  = 3'd0;
	localparam dev_idx_t DEV_GP0     = 3'd1;
	localparam dev_idx_t DEV_GP1     = 3'd2;
	localparam dev_idx_t DEV_INTCTRL = 3'd3;
	localparam dev_idx_t DEV_INVALID = 3'd4;
	localparam int       DEVCOUNT    = 5;

	// Word address map, the invalid device takes everything else
	localparam addr_t DEVTBL_BASE   = 30'd0;
	localparam addr_t DEVTBL_MAPSZ  = 30'd16;
	localparam addr_t GP0_BASE      = 30'd16;
	localparam addr_t GP0_MAPSZ     = 30'd4;
	localparam addr_t GP1_BASE      = 30'd20;
	localparam addr_t GP1_MAPSZ     = 30'd4;
	localparam addr_t INTCTRL_BASE  = 30'd24;
	localparam addr_t INTCTRL_MAPSZ = 30'd4;

	localparam logic [7:0] ID_DEVTBL  = 8'd7;
	localparam logic [7:0] ID_GPIO    = 8'd6;
	localparam logic [7:0] ID_INTCTRL = 8'd3;
	localparam logic [7:0] ID_INVALID = 8'd0;

	localparam word_t SOC_ID = 32'd2;

	// Register word offsets
	localparam logic [3:0] DT_SOCID_OFS = 4'd0;
	localparam logic [3:0] DT_COUNT_OFS = 4'd1;
	localparam logic [3:0] DT_ENTRY_OFS = 4'd2;
	localparam logic [3:0] DT_RST_OFS   = 4'd15;
	localparam logic [3:0] GP_IN_OFS    = 4'd0;
	localparam logic [3:0] GP_OUT_OFS   = 4'd1;
	localparam logic [3:0] IC_PEND_OFS  = 4'd0;
	localparam logic [3:0] IC_EN_OFS    = 4'd1;

	localparam int INTSRC_GP0   = 0;
	localparam int INTSRC_GP1   = 1;
	localparam int INTSRC_COUNT = 2;

	// Entry word: map size in 31..16, interrupt use in 8, id in 7..0
	function automatic word_t dev_entry(input dev_idx_t idx);
		logic [7:0]  id;
		logic        irq_use;
		logic [15:0] mapsz;
		id      = ID_INVALID;
		irq_use = 1'b0;
		mapsz   = 16'd0;
		case (idx)
			DEV_DEVTBL: begin
				id    = ID_DEVTBL;
				mapsz = 16'(DEVTBL_MAPSZ);
			end
			DEV_GP0: begin
				id      = ID_GPIO;
				irq_use = 1'b1;
				mapsz   = 16'(GP0_MAPSZ);
			end
			DEV_GP1: begin
				id      = ID_GPIO;
				irq_use = 1'b1;
				mapsz   = 16'(GP1_MAPSZ);
			end
			DEV_INTCTRL: begin
				id      = ID_INTCTRL;
				irq_use = 1'b1;
				mapsz   = 16'(INTCTRL_MAPSZ);
			end
			default: ;
		endcase
		return {mapsz, 7'd0, irq_use, id};
	endfunction

	function automatic logic op_writes(input pi_op_e op);
		return (op == OP_WR) || (op == OP_RW);
	endfunction

	// Byte lanes with their enable set take the new data
	function automatic word_t be_merge(input word_t old_val, input word_t new_val, input sel_t be);
		word_t res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = be[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
		end
		return res;
	endfunction

endpackage

// File: sources.f
+incdir+include
hdl/soc_pkg.sv
hdl/reset_seq.sv
hdl/pi_decode.sv
hdl/devtbl_regs.sv
hdl/gpio_port.sv
hdl/intctrl.sv
hdl/pi_respmux.sv
hdl/soc_periph_top.sv
dv/tb_soc_periph.sv
